//--- include/decoder.svh
`ifndef DECODER_SVH
`define DECODER_SVH

// operation groups, selected by grand_op
`define _ALU_GTYPE_LI   2'b00
`define _ALU_GTYPE_INT  2'b01
`define _ALU_GTYPE_SFT  2'b10
`define _ALU_GTYPE_CMP  2'b11

// logic group
`define _ALU_STYPE_NOR  2'b00
`define _ALU_STYPE_AND  2'b01
`define _ALU_STYPE_OR   2'b10
`define _ALU_STYPE_XOR  2'b11

// add/sub group, only op[1] is decoded
`define _ALU_STYPE_ADD  2'b00
`define _ALU_STYPE_SUB  2'b10

// shift group, 2'b11 falls back to sll
`define _ALU_STYPE_SLL  2'b00
`define _ALU_STYPE_SRL  2'b01
`define _ALU_STYPE_SRA  2'b10

// compare group, op[0] set means signed
`define _ALU_STYPE_SLTU 2'b00
`define _ALU_STYPE_SLT  2'b01

// immediate forms for builds without the add/sub group
`define _ALU_STYPE_LUI     2'b01
`define _ALU_STYPE_PCPLUS4 2'b10
`define _ALU_STYPE_PCADDUI 2'b11

`endif

//--- hw/alu_pkg.sv
`default_nettype none

package alu_pkg;

  // datapath width
  localparam int XLEN = 32;

  // tag carried from issue to result
  localparam int TAG_W = 4;

  // one issued operation
  // r0 is the second operand in sub, shifts and compares
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [1:0]       grand_op;
    logic [1:0]       op;
    logic [XLEN-1:0]  r0;
    logic [XLEN-1:0]  r1;
    logic [XLEN-1:0]  pc;
    logic [XLEN-1:0]  mul;
  } alu_req_t;

  // one finished operation, tag echoed back
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  res;
  } alu_rsp_t;

endpackage

`default_nettype wire

//--- hw/core_detachable_alu.sv
`default_nettype none

`include "decoder.svh"

module core_detachable_alu import alu_pkg::*; #(
  parameter bit USE_LI  = 1,
  parameter bit USE_INT = 1,
  parameter bit USE_MUL = 0,
  parameter bit USE_SFT = 1,
  parameter bit USE_CMP = 1
) (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic [XLEN-1:0] mul_i,
  input  logic [XLEN-1:0] r0_i,
  input  logic [XLEN-1:0] r1_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [1:0]      grand_op_i,
  input  logic [1:0]      op_i,
  output logic [XLEN-1:0] res_o
);

  // groups 0/1 and groups 2/3 form the two halves of the select
  localparam bit HAS_LOW  = USE_LI || USE_INT || USE_MUL;
  localparam bit HAS_HIGH = USE_SFT || USE_CMP;

  logic [XLEN-1:0] g0_result;
  logic [XLEN-1:0] g1_result;
  logic [XLEN-1:0] g2_result;
  logic [XLEN-1:0] g3_result;

  if (HAS_LOW && HAS_HIGH) begin : g_sel4
    always_comb begin
      case (grand_op_i)
        `_ALU_GTYPE_INT: res_o = g1_result;
        `_ALU_GTYPE_SFT: res_o = g2_result;
        `_ALU_GTYPE_CMP: res_o = g3_result;
        default:         res_o = g0_result;
      endcase
    end
  end else if (HAS_LOW) begin : g_sel2_low
    // only bit 0 matters with the upper half gone
    assign res_o = grand_op_i[0] ? g1_result : g0_result;
  end else if (HAS_HIGH) begin : g_sel2_high
    assign res_o = grand_op_i[0] ? g3_result : g2_result;
  end else begin : g_sel_none
    assign res_o = '0;
  end

  if (USE_LI) begin : g_li
    always_comb begin
      case (op_i)
        `_ALU_STYPE_NOR: g0_result = ~(r1_i | r0_i);
        `_ALU_STYPE_AND: g0_result = r1_i & r0_i;
        `_ALU_STYPE_OR:  g0_result = r1_i | r0_i;
        default:         g0_result = r1_i ^ r0_i;
      endcase
    end
  end else begin : g_no_li
    assign g0_result = '0;
  end

  if (USE_INT) begin : g_int
    // op[1] picks subtract
    assign g1_result = op_i[1] ? (r1_i - r0_i) : (r1_i + r0_i);
  end else if (USE_LI) begin : g_imm
    always_comb begin
      case (op_i)
        `_ALU_STYPE_PCPLUS4: g1_result = pc_i + XLEN'(4);
        `_ALU_STYPE_PCADDUI: g1_result = pc_i + r0_i;
        // lui
        default:             g1_result = {r0_i[19:0], 12'd0};
      endcase
    end
  end else if (USE_MUL) begin : g_mul
    // product computed outside, only muxed in here
    assign g1_result = mul_i;
  end else begin : g_no_int
    assign g1_result = '0;
  end

  if (USE_SFT) begin : g_sft
    always_comb begin
      case (op_i)
        `_ALU_STYPE_SRL: g2_result = r1_i >> r0_i[4:0];
        `_ALU_STYPE_SRA: g2_result = $signed(r1_i) >>> r0_i[4:0];
        default:         g2_result = r1_i << r0_i[4:0];
      endcase
    end
  end else begin : g_no_sft
    assign g2_result = '0;
  end

  if (USE_CMP) begin : g_cmp
    logic            is_signed;
    logic [XLEN:0]   a_ext;
    logic [XLEN:0]   b_ext;

    // sign or zero extend by one bit, then one signed compare covers slt and sltu
    assign is_signed = op_i[0];
    assign a_ext     = {r1_i[XLEN-1] & is_signed, r1_i};
    assign b_ext     = {r0_i[XLEN-1] & is_signed, r0_i};
    assign g3_result = {{(XLEN-1){1'b0}}, $signed(a_ext) < $signed(b_ext)};
  end else begin : g_no_cmp
    assign g3_result = '0;
  end

endmodule

`default_nettype wire

//--- hw/alu_lane.sv
`default_nettype none

module alu_lane import alu_pkg::*; #(
  parameter int LANE_DEPTH = 2,
  parameter bit USE_LI     = 1,
  parameter bit USE_INT    = 1,
  parameter bit USE_MUL    = 0,
  parameter bit USE_SFT    = 1,
  parameter bit USE_CMP    = 1
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  alu_req_t req_i,
  output logic     credit_o,
  input  logic     grant_i,
  output logic     rsp_valid_o,
  output alu_rsp_t rsp_o
);

  localparam int PTR_W = (LANE_DEPTH > 1) ? $clog2(LANE_DEPTH) : 1;
  localparam int CNT_W = $clog2(LANE_DEPTH + 1);

  alu_req_t             queue_q [LANE_DEPTH];
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [CNT_W-1:0]     count_q;
  alu_req_t             head;
  logic [XLEN-1:0]      alu_res;
  logic                 pop;
  logic                 rsp_valid_q;
  alu_rsp_t             rsp_q;

  assign head = queue_q[rd_ptr_q];

  // head moves into the result register when it is free or being drained
  assign pop      = (count_q != '0) && (!rsp_valid_q || grant_i);
  assign credit_o = pop;

  core_detachable_alu #(
    .USE_LI  (USE_LI),
    .USE_INT (USE_INT),
    .USE_MUL (USE_MUL),
    .USE_SFT (USE_SFT),
    .USE_CMP (USE_CMP)
  ) u_alu (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .mul_i      (head.mul),
    .r0_i       (head.r0),
    .r1_i       (head.r1),
    .pc_i       (head.pc),
    .grand_op_i (head.grand_op),
    .op_i       (head.op),
    .res_o      (alu_res)
  );

  always_ff @(posedge clk) begin
    if (push_i) begin
      queue_q[wr_ptr_q] <= req_i;
    end
    if (pop) begin
      rsp_q <= '{tag: head.tag, res: alu_res};
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q    <= '0;
      wr_ptr_q    <= '0;
      count_q     <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(LANE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(LANE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop);
      if (pop) begin
        rsp_valid_q <= 1'b1;
      end else if (grant_i) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

`default_nettype wire

//--- hw/issue_dispatch.sv
`default_nettype none

module issue_dispatch import alu_pkg::*; #(
  parameter int NUM_LANES  = 3,
  parameter int LANE_DEPTH = 2
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 req_valid_i,
  input  alu_req_t             req_i,
  output logic                 req_ready_o,
  output logic [NUM_LANES-1:0] lane_push_o,
  output alu_req_t             lane_req_o,
  input  logic [NUM_LANES-1:0] lane_credit_i
);

  localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam int CNT_W  = $clog2(LANE_DEPTH + 1);

  logic [CNT_W-1:0]     credit_q [NUM_LANES];
  logic [NUM_LANES-1:0] has_credit;
  logic [LANE_W-1:0]    last_q;
  logic [LANE_W-1:0]    sel;
  logic                 accept;

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      has_credit[i] = (credit_q[i] != '0);
    end
  end

  // first lane with credit after the last one used
  always_comb begin
    int   idx;
    logic found;
    found = 1'b0;
    sel   = last_q;
    for (int i = 1; i <= NUM_LANES; i++) begin
      idx = int'(last_q) + i;
      if (idx >= NUM_LANES) begin
        idx = idx - NUM_LANES;
      end
      if (!found && has_credit[idx]) begin
        found = 1'b1;
        sel   = LANE_W'(idx);
      end
    end
  end

  assign req_ready_o = |has_credit;
  assign accept      = req_valid_i && req_ready_o;
  assign lane_req_o  = req_i;

  always_comb begin
    lane_push_o = '0;
    if (accept) begin
      lane_push_o[sel] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // start so that lane 0 is picked first
      last_q <= LANE_W'(NUM_LANES - 1);
      for (int i = 0; i < NUM_LANES; i++) begin
        credit_q[i] <= CNT_W'(LANE_DEPTH);
      end
    end else begin
      if (accept) begin
        last_q <= sel;
      end
      // push and return in one cycle cancel out
      for (int i = 0; i < NUM_LANES; i++) begin
        credit_q[i] <= credit_q[i] + CNT_W'(lane_credit_i[i]) - CNT_W'(lane_push_o[i]);
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/result_collect.sv
`default_nettype none

module result_collect import alu_pkg::*; #(
  parameter int NUM_LANES   = 3,
  parameter int OUT_CREDITS = 2
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic [NUM_LANES-1:0] lane_valid_i,
  input  alu_rsp_t             lane_rsp_i [NUM_LANES],
  output logic [NUM_LANES-1:0] lane_grant_o,
  output logic                 res_valid_o,
  output alu_rsp_t             res_o,
  input  logic                 res_credit_i
);

  localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam int CNT_W  = $clog2(OUT_CREDITS + 1);

  logic [CNT_W-1:0]  out_cnt_q;
  logic [LANE_W-1:0] last_q;
  logic [LANE_W-1:0] sel;
  logic              found;
  logic              grant;

  // next valid lane after the last one drained
  always_comb begin
    int idx;
    found = 1'b0;
    sel   = last_q;
    for (int i = 1; i <= NUM_LANES; i++) begin
      idx = int'(last_q) + i;
      if (idx >= NUM_LANES) begin
        idx = idx - NUM_LANES;
      end
      if (!found && lane_valid_i[idx]) begin
        found = 1'b1;
        sel   = LANE_W'(idx);
      end
    end
  end

  // no credit, no grant
  assign grant = found && (out_cnt_q != '0);

  always_comb begin
    lane_grant_o = '0;
    if (grant) begin
      lane_grant_o[sel] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      res_o <= lane_rsp_i[sel];
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_cnt_q   <= CNT_W'(OUT_CREDITS);
      last_q      <= LANE_W'(NUM_LANES - 1);
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= grant;
      out_cnt_q   <= out_cnt_q + CNT_W'(res_credit_i) - CNT_W'(grant);
      if (grant) begin
        last_q <= sel;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/exec_cluster.sv
`default_nettype none

module exec_cluster import alu_pkg::*; #(
  parameter int NUM_LANES   = 3,
  parameter int LANE_DEPTH  = 2,
  parameter int OUT_CREDITS = 2,
  parameter bit USE_LI      = 1,
  parameter bit USE_INT     = 1,
  parameter bit USE_MUL     = 0,
  parameter bit USE_SFT     = 1,
  parameter bit USE_CMP     = 1
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     req_valid_i,
  input  alu_req_t req_i,
  output logic     req_ready_o,
  output logic     res_valid_o,
  output alu_rsp_t res_o,
  input  logic     res_credit_i
);

  logic [NUM_LANES-1:0] lane_push;
  alu_req_t             lane_req;
  logic [NUM_LANES-1:0] lane_credit;
  logic [NUM_LANES-1:0] lane_valid;
  alu_rsp_t             lane_rsp [NUM_LANES];
  logic [NUM_LANES-1:0] lane_grant;

  issue_dispatch #(
    .NUM_LANES  (NUM_LANES),
    .LANE_DEPTH (LANE_DEPTH)
  ) u_dispatch (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_ready_o   (req_ready_o),
    .lane_push_o   (lane_push),
    .lane_req_o    (lane_req),
    .lane_credit_i (lane_credit)
  );

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    alu_lane #(
      .LANE_DEPTH (LANE_DEPTH),
      .USE_LI     (USE_LI),
      .USE_INT    (USE_INT),
      .USE_MUL    (USE_MUL),
      .USE_SFT    (USE_SFT),
      .USE_CMP    (USE_CMP)
    ) u_lane (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .push_i      (lane_push[i]),
      .req_i       (lane_req),
      .credit_o    (lane_credit[i]),
      .grant_i     (lane_grant[i]),
      .rsp_valid_o (lane_valid[i]),
      .rsp_o       (lane_rsp[i])
    );
  end

  result_collect #(
    .NUM_LANES   (NUM_LANES),
    .OUT_CREDITS (OUT_CREDITS)
  ) u_collect (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .lane_valid_i (lane_valid),
    .lane_rsp_i   (lane_rsp),
    .lane_grant_o (lane_grant),
    .res_valid_o  (res_valid_o),
    .res_o        (res_o),
    .res_credit_i (res_credit_i)
  );

endmodule

`default_nettype wire

//--- tests/exec_cluster_asserts.sv
`default_nettype none

module exec_cluster_asserts #(
  parameter int NUM_LANES   = 3,
  parameter int OUT_CREDITS = 2
) (
  input logic                 clk,
  input logic                 rst_n_i,
  input logic                 req_ready_i,
  input logic                 res_valid_i,
  input logic                 res_credit_i,
  input logic [NUM_LANES-1:0] lane_grant_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // credits the consumer has granted but not yet seen used
  int avail_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      avail_q <= OUT_CREDITS;
    end else begin
      avail_q <= avail_q + int'(res_credit_i) - int'(res_valid_i);
    end
  end

  ready_after_reset: assert property (@(posedge clk) rst_n_i && !$past(rst_n_i) |-> req_ready_i)
    else $error("req_ready_o low in the first cycle after reset");

  valid_within_credits: assert property (@(posedge clk) disable iff (!rst_n_i)
    res_valid_i |-> avail_q > 0)
    else $error("res_valid_o without an output credit");

  quiet_in_reset: assert property (@(posedge clk) !rst_n_i |-> !res_valid_i && lane_grant_i == '0)
    else $error("output or lane grant active during reset");

endmodule

bind exec_cluster exec_cluster_asserts #(
  .NUM_LANES   (NUM_LANES),
  .OUT_CREDITS (OUT_CREDITS)
) u_asserts (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .req_ready_i  (req_ready_o),
  .res_valid_i  (res_valid_o),
  .res_credit_i (res_credit_i),
  .lane_grant_i (lane_grant)
);

`default_nettype wire

//--- tests/tb_exec_cluster.sv
`default_nettype none

`include "decoder.svh"

module tb_exec_cluster import alu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_LANES   = 3;
  localparam int LANE_DEPTH  = 2;
  localparam int OUT_CREDITS = 2;
  localparam int NUM_TAGS    = 1 << TAG_W;
  localparam int TIMEOUT     = 400;

  logic       clk = 1'b0;
  logic       rst_n_i = 1'b0;
  logic       req_valid_i = 1'b0;
  alu_req_t   req_i = '0;
  logic       req_ready_o;
  logic       res_valid_o;
  alu_rsp_t   res_o;
  logic       res_credit_i = 1'b0;

  // expected value per tag, outstanding = issued minus returned
  logic [XLEN-1:0]  exp_res [NUM_TAGS];
  int               issued_cnt [NUM_TAGS];
  int               got_cnt [NUM_TAGS];
  int               errors = 0;
  int               rsp_errors = 0;
  int               received = 0;
  int               returned = 0;
  bit               credit_en = 1'b1;
  logic [31:0]      lcg_state = 32'd15267;
  logic [TAG_W-1:0] next_tag = '0;

  exec_cluster #(
    .NUM_LANES   (NUM_LANES),
    .LANE_DEPTH  (LANE_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) u_dut (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .res_valid_o  (res_valid_o),
    .res_o        (res_o),
    .res_credit_i (res_credit_i)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // reference result, r1 is the first operand
  function automatic logic [XLEN-1:0] expected_res(input alu_req_t r);
    logic [XLEN-1:0]   res;
    logic [2*XLEN-1:0] wide;
    case (r.grand_op)
      `_ALU_GTYPE_LI: begin
        case (r.op)
          `_ALU_STYPE_NOR: res = ~(r.r1 | r.r0);
          `_ALU_STYPE_AND: res = r.r1 & r.r0;
          `_ALU_STYPE_OR:  res = r.r1 | r.r0;
          default:         res = r.r1 ^ r.r0;
        endcase
      end
      `_ALU_GTYPE_INT: res = r.op[1] ? r.r1 - r.r0 : r.r1 + r.r0;
      `_ALU_GTYPE_SFT: begin
        // arithmetic shift as a logical shift of the sign-filled double word
        wide = {{XLEN{r.r1[XLEN-1]}}, r.r1} >> r.r0[4:0];
        case (r.op)
          `_ALU_STYPE_SRL: res = r.r1 >> r.r0[4:0];
          `_ALU_STYPE_SRA: res = wide[XLEN-1:0];
          default:         res = r.r1 << r.r0[4:0];
        endcase
      end
      default: begin
        if (r.op[0]) begin
          res = XLEN'($signed(r.r1) < $signed(r.r0));
        end else begin
          res = XLEN'(r.r1 < r.r0);
        end
      end
    endcase
    return res;
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      n += issued_cnt[t] - got_cnt[t];
    end
    return n;
  endfunction

  task automatic check_rsp(input alu_rsp_t got);
    if (got_cnt[got.tag] >= issued_cnt[got.tag]) begin
      $display("result for tag %0d arrived with nothing outstanding at %0t", got.tag, $time);
      rsp_errors++;
    end else begin
      if (got.res !== exp_res[got.tag]) begin
        $display("ERR %0t res_o.res tag %0d got %h expected %h",
                 $time, got.tag, got.res, exp_res[got.tag]);
        rsp_errors++;
      end
      got_cnt[got.tag]++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // sink, check every result on the falling edge
  always @(negedge clk) begin
    if (rst_n_i && res_valid_o) begin
      check_rsp(res_o);
      received++;
    end
  end

  // one credit back per result unless held
  always @(posedge clk) begin
    #2;
    if (credit_en && (received > returned)) begin
      res_credit_i = 1'b1;
      returned++;
    end else begin
      res_credit_i = 1'b0;
    end
  end

  task automatic issue(input alu_req_t r);
    int tag_cycles;
    int cycles;
    tag_cycles = 0;
    cycles     = 0;
    // tag must be free before reuse
    while ((issued_cnt[r.tag] != got_cnt[r.tag]) && tag_cycles < TIMEOUT) begin
      @(posedge clk);
      #2;
      tag_cycles++;
    end
    if (issued_cnt[r.tag] != got_cnt[r.tag]) begin
      $display("tag %0d never came back, request not issued", r.tag);
      errors++;
      return;
    end
    exp_res[r.tag] = expected_res(r);
    issued_cnt[r.tag]++;
    req_i       = r;
    req_valid_i = 1'b1;
    while (!req_ready_o && cycles < TIMEOUT) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!req_ready_o) begin
      $display("request with tag %0d was never accepted", r.tag);
      errors++;
      issued_cnt[r.tag]--;
      req_valid_i = 1'b0;
      return;
    end
    @(posedge clk);
    #2;
    req_valid_i = 1'b0;
  endtask

  task automatic send_op(input logic [1:0] gop, input logic [1:0] op,
                         input logic [XLEN-1:0] r1, input logic [XLEN-1:0] r0);
    alu_req_t r;
    r          = '0;
    r.tag      = next_tag;
    r.grand_op = gop;
    r.op       = op;
    r.r1       = r1;
    r.r0       = r0;
    r.pc       = 32'h0000_1000;
    next_tag   = next_tag + 1'b1;
    issue(r);
  endtask

  task automatic send_random();
    logic [31:0] sel;
    logic [31:0] a;
    logic [31:0] b;
    lcg_state = lcg_next(lcg_state);
    sel       = lcg_state;
    lcg_state = lcg_next(lcg_state);
    a         = lcg_state;
    lcg_state = lcg_next(lcg_state);
    b         = lcg_state;
    send_op(sel[31:30], sel[29:28], a, b);
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (pending_count() != 0 && cycles < TIMEOUT) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (pending_count() != 0) begin
      $display("%0d results never arrived", pending_count());
      errors++;
    end
  endtask

  // all returned credits back in the collector
  task automatic settle_credits();
    int cycles;
    cycles = 0;
    while (returned != received && cycles < TIMEOUT) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (returned != received) begin
      $display("output credits were not all returned");
      errors++;
    end
    @(posedge clk);
    #2;
  endtask

  task automatic test_reset();
    check_bit("req_ready_o", req_ready_o, 1'b1);
    repeat (5) begin
      @(posedge clk);
      #2;
      check_bit("res_valid_o", res_valid_o, 1'b0);
    end
  endtask

  task automatic test_directed();
    send_op(`_ALU_GTYPE_LI, `_ALU_STYPE_NOR, 32'hF0F0_0000, 32'h0F0F_00FF);
    send_op(`_ALU_GTYPE_LI, `_ALU_STYPE_AND, 32'hFF00_FF00, 32'h0FF0_0FF0);
    send_op(`_ALU_GTYPE_LI, `_ALU_STYPE_OR, 32'h1234_0000, 32'h0000_5678);
    send_op(`_ALU_GTYPE_LI, `_ALU_STYPE_XOR, 32'hAAAA_5555, 32'hFFFF_0000);
    send_op(`_ALU_GTYPE_INT, `_ALU_STYPE_ADD, 32'h7FFF_FFFF, 32'h0000_0001);
    // 5 - 7 wraps below zero
    send_op(`_ALU_GTYPE_INT, `_ALU_STYPE_SUB, 32'd5, 32'd7);
    send_op(`_ALU_GTYPE_SFT, `_ALU_STYPE_SLL, 32'h0000_00F1, 32'd4);
    send_op(`_ALU_GTYPE_SFT, `_ALU_STYPE_SRL, 32'h8000_0000, 32'd4);
    send_op(`_ALU_GTYPE_SFT, `_ALU_STYPE_SRA, 32'h8000_1234, 32'd8);
    send_op(`_ALU_GTYPE_SFT, 2'b11, 32'h0000_0003, 32'd31);
    // mixed signs flip between slt and sltu
    send_op(`_ALU_GTYPE_CMP, `_ALU_STYPE_SLT, 32'hFFFF_FFFF, 32'd1);
    send_op(`_ALU_GTYPE_CMP, `_ALU_STYPE_SLTU, 32'hFFFF_FFFF, 32'd1);
    send_op(`_ALU_GTYPE_CMP, `_ALU_STYPE_SLT, 32'd1, 32'hFFFF_FFFF);
    send_op(`_ALU_GTYPE_CMP, `_ALU_STYPE_SLTU, 32'd1, 32'hFFFF_FFFF);
    wait_idle();
  endtask

  task automatic test_random();
    repeat (60) begin
      send_random();
    end
    wait_idle();
  endtask

  task automatic test_credit_hold();
    int base;
    int cycles;
    settle_credits();
    credit_en = 1'b0;
    base      = received;
    repeat (5) begin
      send_random();
    end
    cycles = 0;
    while ((received - base) < OUT_CREDITS && cycles < TIMEOUT) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    // nothing more may leave while credits are held
    repeat (10) begin
      @(posedge clk);
      #2;
    end
    if ((received - base) != OUT_CREDITS) begin
      $display("%0d results left with %0d output credits", received - base, OUT_CREDITS);
      errors++;
    end
    credit_en = 1'b1;
    wait_idle();
  endtask

  task automatic test_backpressure();
    int sent;
    int cycles;
    settle_credits();
    credit_en = 1'b0;
    sent      = 0;
    while (req_ready_o && sent < 24) begin
      send_random();
      sent++;
    end
    check_bit("req_ready_o", req_ready_o, 1'b0);
    credit_en = 1'b1;
    cycles    = 0;
    while (!req_ready_o && cycles < TIMEOUT) begin
      @(posedge clk);
      #2;
      cycles++;
    end
    check_bit("req_ready_o", req_ready_o, 1'b1);
    wait_idle();
  endtask

  initial begin
    int total;
    repeat (8) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    test_reset();
    test_directed();
    test_random();
    test_credit_hold();
    test_backpressure();
    total = errors + rsp_errors;
    $display("errors %0d (result checks %0d, other %0d)", total, rsp_errors, errors);
    if (total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
hw/alu_pkg.sv
hw/core_detachable_alu.sv
hw/alu_lane.sv
hw/issue_dispatch.sv
hw/result_collect.sv
hw/exec_cluster.sv
tests/exec_cluster_asserts.sv
tests/tb_exec_cluster.sv

//--- Makefile
SIM      = verilator
TOP      = tb_exec_cluster
FILELIST = vlog.f
FLAGS    = --binary --timing --assert --top-module $(TOP)
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
